/* verilog/arm_config.svh */
// ARM core configuration macros for data width, register count and PC stepping
`ifndef ARM_CONFIG_SVH
`define ARM_CONFIG_SVH

// Data and address width
`define ARM_XLEN 32

// Architectural registers, R15 included
`define ARM_NREGS 16

// Bytes per instruction
`define ARM_PC_STEP 4

// First fetch address after reset
`define ARM_RESET_PC 32'h0000_0000

`endif

/* verilog/armIsaPkg.sv */
// ARM ISA package with instruction formats and condition codes
package armIsaPkg;

   // Condition field encodings, NV not supported
   typedef enum logic [3:0] {
      EQ = 4'h0,  // Z set
      NE,         // Z clear
      CS,         // C set
      CC,         // C clear
      MI,         // N set
      PL,         // N clear
      VS,         // V set
      VC,         // V clear
      HI,         // C set and Z clear
      LS,         // C clear or Z set
      GE,         // N equals V
      LT,         // N differs from V
      GT,         // Z clear and N equals V
      LE,         // Z set or N differs from V
      AL          // Always
   } condCode_e;

   // Data processing view, op = 00
   typedef struct packed {
      condCode_e   cond;
      logic [1:0]  op;
      logic        imm;   // 1 for imm8, 0 for rm
      logic [3:0]  cmd;   // ALU command
      logic        s;     // Update flags
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] src2;  // imm8 or rm in low bits
   } dpInstr_s;

   // Load/store view, op = 01
   typedef struct packed {
      condCode_e   cond;
      logic [1:0]  op;
      logic        regOffset;  // Only immediate offsets handled
      logic [3:0]  pubw;       // Pre, up, byte, writeback
      logic        l;          // 1 for LDR
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;
   } memInstr_s;

   // Branch view, op = 10
   typedef struct packed {
      condCode_e   cond;
      logic [1:0]  op;
      logic        fmt;    // Always 1 for B
      logic        link;   // BL not supported
      logic [23:0] imm24;  // Word offset, signed
   } brInstr_s;

   // One fetched word, read through the view op selects
   typedef union packed {
      dpInstr_s  dp;
      memInstr_s mem;
      brInstr_s  br;
   } instrWord_u;

endpackage

/* verilog/armCtrlPkg.sv */
// ARM control package with ALU ops, immediate sources, flags and the control word
package armCtrlPkg;

   // Supported ALU operations
   typedef enum logic [1:0] {
      ADD = 2'b00,
      SUB = 2'b01,
      AND = 2'b10,
      ORR = 2'b11
   } aluOp_e;

   // Immediate extension modes
   typedef enum logic [1:0] {
      IMM8     = 2'b00,  // Zero extended
      IMM12    = 2'b01,  // Zero extended
      BRANCH24 = 2'b10   // Sign extended, times 4
   } immSrc_e;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } aluFlags_s;

   // Unconditional decode result, gated later by the condition check
   typedef struct packed {
      logic [1:0] regSrc;       // [0] rn to R15, [1] rm to rd
      immSrc_e    immSrc;
      logic       aluSrc;       // Immediate as source B
      logic       memToReg;     // Writeback from memory
      logic       regWrite;
      logic       memWrite;
      logic       branch;
      aluOp_e     aluOp;
      logic       flagWriteNz;
      logic       flagWriteCv;
   } ctrlWord_s;

endpackage

/* verilog/instrDecoder.sv */
// Instruction decoder turning the fetched word into the core control word
`timescale 1ns/1ns

module instrDecoder (
   input  armIsaPkg::instrWord_u instr,
   output armCtrlPkg::ctrlWord_s ctrl
);
   import armCtrlPkg::*;

   aluOp_e dpOp;     // ALU op from cmd field
   logic   dpLegal;  // cmd is one of the four kept

   // ALU decoder
   always_comb begin
      dpLegal = 1'b1;
      case (instr.dp.cmd)
         4'b0100: dpOp = ADD;
         4'b0010: dpOp = SUB;
         4'b0000: dpOp = AND;
         4'b1100: dpOp = ORR;
         default: begin
            dpOp    = ADD;
            dpLegal = 1'b0;  // Dropped ops decode as no-op
         end
      endcase
   end

   // Main decoder
   always_comb begin
      ctrl       = '0;
      ctrl.aluOp = ADD;  // Address and target adds
      case (instr.dp.op)
         2'b00: begin  // Data processing
            ctrl.immSrc      = IMM8;
            ctrl.aluSrc      = instr.dp.imm;
            ctrl.regWrite    = dpLegal;
            ctrl.aluOp       = dpOp;
            ctrl.flagWriteNz = instr.dp.s & dpLegal;
            // C and V only from arithmetic
            ctrl.flagWriteCv = instr.dp.s & dpLegal & ((dpOp == ADD) || (dpOp == SUB));
         end
         2'b01: begin  // LDR / STR
            ctrl.immSrc = IMM12;
            ctrl.aluSrc = 1'b1;
            if (!instr.mem.regOffset) begin
               if (instr.mem.l) begin
                  ctrl.regWrite = 1'b1;
                  ctrl.memToReg = 1'b1;
               end else begin
                  ctrl.regSrc[1] = 1'b1;  // Port B reads rd for store data
                  ctrl.memWrite  = 1'b1;
               end
            end
         end
         2'b10: begin  // B, BL ignored
            if (instr.br.fmt && !instr.br.link) begin
               ctrl.regSrc[0] = 1'b1;  // Base is PC+8
               ctrl.immSrc    = BRANCH24;
               ctrl.aluSrc    = 1'b1;
               ctrl.branch    = 1'b1;
            end
         end
         default: ctrl = '0;  // Coprocessor space unsupported
      endcase
   end

endmodule

/* verilog/condUnit.sv */
// Condition unit holding the flags and gating every state write
`timescale 1ns/1ns

module condUnit (
   input  logic                  clk,
   input  logic                  reset,
   input  armIsaPkg::condCode_e  cond,
   input  armCtrlPkg::ctrlWord_s ctrl,
   input  armCtrlPkg::aluFlags_s aluFlags,
   input  logic                  pcReady,
   output logic                  regWriteEn,
   output logic                  memWrite,
   output logic                  pcSrc
);
   import armIsaPkg::*;
   import armCtrlPkg::*;

   logic [1:0] nzQ;        // Stored N, Z
   logic [1:0] cvQ;        // Stored C, V
   aluFlags_s  flags;
   logic       condEx;     // Condition holds
   logic       writeOk;    // Condition holds and not stalled
   logic [1:0] flagsEn;    // {nz, cv}

   // Flags update independently
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         nzQ <= '0;
         cvQ <= '0;
      end else begin
         if (flagsEn[1]) nzQ <= {aluFlags.n, aluFlags.z};
         if (flagsEn[0]) cvQ <= {aluFlags.c, aluFlags.v};
      end
   end

   assign flags = {nzQ, cvQ};

   // Condition table against stored flags
   always_comb begin
      case (cond)
         EQ:      condEx = flags.z;
         NE:      condEx = ~flags.z;
         CS:      condEx = flags.c;
         CC:      condEx = ~flags.c;
         MI:      condEx = flags.n;
         PL:      condEx = ~flags.n;
         VS:      condEx = flags.v;
         VC:      condEx = ~flags.v;
         HI:      condEx = flags.c & ~flags.z;
         LS:      condEx = ~flags.c | flags.z;
         GE:      condEx = (flags.n == flags.v);
         LT:      condEx = (flags.n != flags.v);
         GT:      condEx = ~flags.z & (flags.n == flags.v);
         LE:      condEx = flags.z | (flags.n != flags.v);
         AL:      condEx = 1'b1;
         default: condEx = 1'b0;  // NV never executes
      endcase
   end

   assign writeOk    = condEx & pcReady;
   assign flagsEn    = {ctrl.flagWriteNz, ctrl.flagWriteCv} & {2{writeOk}};
   assign regWriteEn = ctrl.regWrite & writeOk;
   assign memWrite   = ctrl.memWrite & writeOk;  // Low through any stall
   assign pcSrc      = ctrl.branch & writeOk;

endmodule

/* verilog/pcUnit.sv */
// Program counter with fetch stall, PC+4, PC+8 and next-PC select
`timescale 1ns/1ns
`include "arm_config.svh"

module pcUnit (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 pcReady,
   input  logic                 pcSrc,
   input  logic [`ARM_XLEN-1:0] result,
   output logic [`ARM_XLEN-1:0] pc,
   output logic [`ARM_XLEN-1:0] pcPlus4,
   output logic [`ARM_XLEN-1:0] pcPlus8
);

   logic [`ARM_XLEN-1:0] pcNext;

   assign pcPlus4 = pc + `ARM_XLEN'(`ARM_PC_STEP);
   assign pcPlus8 = pcPlus4 + `ARM_XLEN'(`ARM_PC_STEP);  // R15 read value
   assign pcNext  = pcSrc ? result : pcPlus4;            // Taken branch or sequential

   // Holds while fetch stalls
   always_ff @(posedge clk or posedge reset) begin
      if (reset) pc <= `ARM_RESET_PC;
      else if (pcReady) pc <= pcNext;
   end

endmodule

/* verilog/regFile.sv */
// Register file with fifteen resettable registers and R15 mapped to PC+8
`timescale 1ns/1ns
`include "arm_config.svh"

module regFile (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 writeEn,
   input  logic [3:0]           readAddrA,
   input  logic [3:0]           readAddrB,
   input  logic [3:0]           writeAddr,
   input  logic [`ARM_XLEN-1:0] writeData,
   input  logic [`ARM_XLEN-1:0] pcPlus8,
   output logic [`ARM_XLEN-1:0] readDataA,
   output logic [`ARM_XLEN-1:0] readDataB
);

   localparam logic [3:0] pcIdx = 4'(`ARM_NREGS - 1);  // R15

   logic [`ARM_XLEN-1:0] regs [`ARM_NREGS-1];  // R0 to R14

   // Write port, R15 writes dropped
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < `ARM_NREGS - 1; i++) regs[i] <= '0;
      end else if (writeEn && (writeAddr != pcIdx)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Combinational reads
   assign readDataA = (readAddrA == pcIdx) ? pcPlus8 : regs[readAddrA];
   assign readDataB = (readAddrB == pcIdx) ? pcPlus8 : regs[readAddrB];

endmodule

/* verilog/execUnit.sv */
// Execute unit with immediate extension, ALU, flags and writeback select
`timescale 1ns/1ns
`include "arm_config.svh"

module execUnit (
   input  armIsaPkg::instrWord_u instr,
   input  armCtrlPkg::ctrlWord_s ctrl,
   input  logic [`ARM_XLEN-1:0]  srcA,
   input  logic [`ARM_XLEN-1:0]  rmData,
   input  logic [`ARM_XLEN-1:0]  readData,
   output logic [`ARM_XLEN-1:0]  aluResult,
   output logic [`ARM_XLEN-1:0]  result,
   output armCtrlPkg::aluFlags_s aluFlags
);
   import armCtrlPkg::*;

   logic [`ARM_XLEN-1:0] extImm;
   logic [`ARM_XLEN-1:0] srcB;
   logic [`ARM_XLEN-1:0] bOp;   // Inverted on SUB
   logic [`ARM_XLEN:0]   sum;   // Carry out on top
   logic                 isSub;
   logic                 isArith;

   // Immediate extension
   always_comb begin
      case (ctrl.immSrc)
         IMM8:     extImm = `ARM_XLEN'(instr.dp.src2[7:0]);
         IMM12:    extImm = `ARM_XLEN'(instr.mem.imm12);
         BRANCH24: extImm = `ARM_XLEN'(signed'({instr.br.imm24, 2'b00}));
         default:  extImm = '0;
      endcase
   end

   assign srcB    = ctrl.aluSrc ? extImm : rmData;
   assign isSub   = (ctrl.aluOp == SUB);
   assign isArith = (ctrl.aluOp == ADD) || isSub;

   // SUB as A + ~B + 1
   assign bOp = isSub ? ~srcB : srcB;
   assign sum = {1'b0, srcA} + {1'b0, bOp} + {{`ARM_XLEN{1'b0}}, isSub};

   always_comb begin
      case (ctrl.aluOp)
         AND:     aluResult = srcA & srcB;
         ORR:     aluResult = srcA | srcB;
         default: aluResult = sum[`ARM_XLEN-1:0];  // ADD and SUB
      endcase
   end

   assign aluFlags.n = aluResult[`ARM_XLEN-1];
   assign aluFlags.z = (aluResult == '0);
   assign aluFlags.c = isArith & sum[`ARM_XLEN];
   // Operands agree in sign, result does not
   assign aluFlags.v = isArith & ~(srcA[`ARM_XLEN-1] ^ srcB[`ARM_XLEN-1] ^ isSub)
                       & (srcA[`ARM_XLEN-1] ^ sum[`ARM_XLEN-1]);

   // Register writeback and branch target
   assign result = ctrl.memToReg ? readData : aluResult;

endmodule

/* verilog/armCore.sv */
// Single-cycle ARMv4 subset core built from decoder, condition, PC, registers and ALU
`timescale 1ns/1ns
`include "arm_config.svh"

module armCore (
   input  logic                  clk,
   input  logic                  reset,
   input  armIsaPkg::instrWord_u instr,
   input  logic [`ARM_XLEN-1:0]  readData,
   input  logic                  pcReady,
   output logic [`ARM_XLEN-1:0]  pc,
   output logic                  memWrite,
   output logic [`ARM_XLEN-1:0]  aluResult,
   output logic [`ARM_XLEN-1:0]  writeData
);
   import armCtrlPkg::*;

   ctrlWord_s            ctrl;
   aluFlags_s            aluFlags;
   logic                 regWriteEn;
   logic                 pcSrc;
   logic [`ARM_XLEN-1:0] pcPlus8;
   logic [`ARM_XLEN-1:0] srcA;
   logic [`ARM_XLEN-1:0] rmData;   // Port B, also store data
   logic [`ARM_XLEN-1:0] result;
   logic [3:0]           readAddrA;
   logic [3:0]           readAddrB;

   // Register address select
   assign readAddrA = ctrl.regSrc[0] ? 4'hF : instr.dp.rn;         // R15 for branches
   assign readAddrB = ctrl.regSrc[1] ? instr.dp.rd : instr.dp.src2[3:0];
   assign writeData = rmData;

   instrDecoder u_decoder (
      .instr (instr),
      .ctrl  (ctrl)
   );

   condUnit u_cond (
      .clk        (clk),
      .reset      (reset),
      .cond       (instr.dp.cond),
      .ctrl       (ctrl),
      .aluFlags   (aluFlags),
      .pcReady    (pcReady),
      .regWriteEn (regWriteEn),
      .memWrite   (memWrite),
      .pcSrc      (pcSrc)
   );

   pcUnit u_pc (
      .clk     (clk),
      .reset   (reset),
      .pcReady (pcReady),
      .pcSrc   (pcSrc),
      .result  (result),
      .pc      (pc),
      .pcPlus4 (),         // Next PC formed inside
      .pcPlus8 (pcPlus8)
   );

   regFile u_regs (
      .clk       (clk),
      .reset     (reset),
      .writeEn   (regWriteEn),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .writeAddr (instr.dp.rd),
      .writeData (result),
      .pcPlus8   (pcPlus8),
      .readDataA (srcA),
      .readDataB (rmData)
   );

   execUnit u_exec (
      .instr     (instr),
      .ctrl      (ctrl),
      .srcA      (srcA),
      .rmData    (rmData),
      .readData  (readData),
      .aluResult (aluResult),  // Data address on loads and stores
      .result    (result),
      .aluFlags  (aluFlags)
   );

endmodule

/* tests/armCore_asserts.sv */
// Bound checker for stall behavior, store writes and PC alignment on the core ports
`timescale 1ns/1ns
`include "arm_config.svh"

module armCore_asserts (
   input logic                  clk,
   input logic                  reset,
   input logic                  pcReady,
   input logic                  memWrite,
   input armIsaPkg::instrWord_u instr,
   input logic [`ARM_XLEN-1:0]  pc
);

   int failCount = 0;  // Read by the testbench at the end

   // PC frozen across a stalled edge
   stallHoldsPc: assert property (@(posedge clk) disable iff (reset) !pcReady |=> $stable(pc))
      else begin failCount++; $error("pc moved while pcReady was low"); end

   // No store while stalled, reset included
   stallNoWrite: assert property (@(posedge clk) !pcReady |-> !memWrite)
      else begin failCount++; $error("memWrite high while pcReady was low"); end

   // Only a store may raise memWrite
   writeOnStore: assert property (@(posedge clk) disable iff (reset)
      memWrite |-> (instr.mem.op == 2'b01) && !instr.mem.l)
      else begin failCount++; $error("memWrite high on an instruction that is not STR"); end

   pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
      else begin failCount++; $error("pc left word alignment"); end

endmodule

bind armCore armCore_asserts u_asserts (.*);

/* tests/armCore_tb.sv */
// Random-instruction testbench for the single-cycle ARM core against an ISA model
`timescale 1ns/1ns
`include "arm_config.svh"

module armCore_tb;

   localparam int numInstr  = 2000;
   localparam int clkPeriod = 8;
   localparam int timeoutNs = (2 * numInstr + 20) * clkPeriod;

   logic                 clk = 1'b0;
   logic                 reset;
   logic [31:0]          instr;
   logic [`ARM_XLEN-1:0] readData;
   logic                 pcReady;
   logic [`ARM_XLEN-1:0] pc;
   logic                 memWrite;
   logic [`ARM_XLEN-1:0] aluResult;
   logic [`ARM_XLEN-1:0] writeData;

   int          errors = 0;
   int          issued = 0;     // Fetches accepted with pcReady high
   logic [31:0] seed   = 32'hd7fb_019c;
   logic        ready;

   // ISA model state
   logic [31:0] mRegs [15];     // R0 to R14
   logic [31:0] mPc;
   logic        mN, mZ, mC, mV;
   logic [31:0] mem [logic [31:0]];

   armCore u_dut (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .readData  (readData),
      .pcReady   (pcReady),
      .pc        (pc),
      .memWrite  (memWrite),
      .aluResult (aluResult),
      .writeData (writeData)
   );

   always #(clkPeriod / 2) clk = ~clk;

   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
      return seed;
   endfunction

   // Unwritten memory words, every address bit mixed in
   function automatic logic [31:0] addrHash(input logic [31:0] addr);
      return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
   endfunction

   function automatic logic [31:0] memRead(input logic [31:0] addr);
      if (mem.exists(addr)) return mem[addr];
      return addrHash(addr);
   endfunction

   function automatic logic [31:0] readReg(input logic [3:0] idx);
      if (idx == 4'hF) return mPc + 32'd8;  // R15 reads PC+8
      return mRegs[idx];
   endfunction

   function automatic logic condHolds(input logic [3:0] cond);
      case (cond)
         4'h0: return mZ;
         4'h1: return !mZ;
         4'h2: return mC;
         4'h3: return !mC;
         4'h4: return mN;
         4'h5: return !mN;
         4'h6: return mV;
         4'h7: return !mV;
         4'h8: return mC && !mZ;
         4'h9: return !mC || mZ;
         4'hA: return mN == mV;
         4'hB: return mN != mV;
         4'hC: return !mZ && (mN == mV);
         4'hD: return mZ || (mN != mV);
         default: return 1'b1;  // AL
      endcase
   endfunction

   // Legal words only, rd below 15 where it is written
   function automatic logic [31:0] randomInstr();
      logic [31:0] r;
      logic [31:0] s;
      logic [31:0] t;
      logic [3:0]  cond;
      logic [3:0]  cmd;
      logic [3:0]  rd;
      logic [31:0] word;
      r    = nextRand();
      s    = nextRand();
      t    = nextRand();
      cond = r[31] ? 4'hE : 4'(r % 15);  // Half unconditional
      rd   = 4'(s % 15);
      case (r[30:28])
         3'd0, 3'd1, 3'd2, 3'd3: begin
            case (r[27:26])
               2'd0:    cmd = 4'b0100;  // ADD
               2'd1:    cmd = 4'b0010;  // SUB
               2'd2:    cmd = 4'b0000;  // AND
               default: cmd = 4'b1100;  // ORR
            endcase
            word = {cond, 2'b00, r[25], cmd, r[24], t[3:0], rd, t[15:4]};
         end
         3'd4:    word = {cond, 2'b01, 1'b0, 4'b1100, 1'b1, t[3:0], rd, 4'h0, t[9:4], 2'b00};
         3'd5,
         3'd6:    word = {cond, 2'b01, 1'b0, 4'b1100, 1'b0, t[3:0], t[23:20], 4'h0, t[9:4],
                          2'b00};
         default: word = {cond, 2'b10, 1'b1, 1'b0, {20{t[3]}}, t[3:0]};  // Short B
      endcase
      return word;
   endfunction

   task automatic compareWord(input string sig, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Fail at %0t ns: %s got %h expected %h", $time, sig, got, exp);
      end
   endtask

   task automatic compareBit(input string sig, input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("Fail at %0t ns: %s got %b expected %b", $time, sig, got, exp);
      end
   endtask

   // One falling edge: check pc, drive a fetch, check outputs, advance the model
   task automatic stepCycle(output logic accepted);
      logic [31:0] r;
      logic [31:0] word;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] addr;
      logic [31:0] rdata;
      logic [31:0] storeData;
      logic [31:0] target;
      logic [32:0] wide;
      logic [1:0]  op;
      logic [3:0]  rd;
      logic        runs;
      logic        isLoad;
      logic        isStore;
      logic        isArith;
      logic        fC;
      logic        fV;
      compareWord("pc", pc, mPc);
      r       = nextRand();
      accepted = (r[31:30] != 2'b00);  // Ready 3 cycles in 4
      word    = randomInstr();
      op      = word[27:26];
      rd      = word[15:12];
      a       = readReg(word[19:16]);
      runs    = accepted && condHolds(word[31:28]);
      rdata   = nextRand();  // Don't care unless a load
      res     = '0;
      addr    = '0;
      storeData = '0;
      target  = '0;
      isLoad  = 1'b0;
      isStore = 1'b0;
      isArith = 1'b0;
      fC      = mC;
      fV      = mV;
      case (op)
         2'b00: begin
            b = word[25] ? {24'h0, word[7:0]} : readReg(word[3:0]);
            case (word[24:21])
               4'b0100: begin
                  wide    = {1'b0, a} + {1'b0, b};
                  res     = wide[31:0];
                  fC      = wide[32];
                  fV      = (a[31] == b[31]) && (res[31] != a[31]);
                  isArith = 1'b1;
               end
               4'b0010: begin
                  res     = a - b;
                  fC      = (a >= b);  // No borrow
                  fV      = (a[31] != b[31]) && (res[31] != a[31]);
                  isArith = 1'b1;
               end
               4'b0000: res = a & b;
               default: res = a | b;
            endcase
         end
         2'b01: begin
            addr      = a + {20'h0, word[11:0]};
            isLoad    = word[20];
            isStore   = !word[20];
            storeData = readReg(rd);
            if (isLoad) rdata = memRead(addr);
         end
         default: target = mPc + 32'd8 + {{6{word[23]}}, word[23:0], 2'b00};
      endcase
      instr    = word;
      pcReady  = accepted;
      readData = rdata;
      #1;
      compareBit("memWrite", memWrite, isStore && runs);
      if (op == 2'b00) compareWord("aluResult", aluResult, res);
      if (op == 2'b01) compareWord("aluResult", aluResult, addr);
      if (isStore) compareWord("writeData", writeData, storeData);
      // State the coming rising edge should leave
      if (runs && op == 2'b00) begin
         mRegs[rd] = res;
         if (word[20]) begin
            mN = res[31];
            mZ = (res == 32'h0);
            if (isArith) begin
               mC = fC;
               mV = fV;
            end
         end
      end
      if (runs && isLoad) mRegs[rd] = rdata;
      if (runs && isStore) mem[addr] = storeData;
      if (accepted) mPc = (runs && op == 2'b10) ? target : mPc + 32'(`ARM_PC_STEP);
   endtask

   initial begin
      reset    = 1'b1;
      instr    = '0;
      readData = '0;
      pcReady  = 1'b0;  // Keeps memWrite low through reset
      mPc      = `ARM_RESET_PC;
      {mN, mZ, mC, mV} = 4'b0000;
      for (int i = 0; i < 15; i++) mRegs[i] = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      while (issued < numInstr) begin
         @(negedge clk);
         stepCycle(ready);
         if (ready) issued++;
      end
      @(negedge clk);
      compareWord("pc", pc, mPc);  // Last fetch
      $display("Check errors: %0d, assertion failures: %0d", errors, u_dut.u_asserts.failCount);
      if (errors == 0 && u_dut.u_asserts.failCount == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog, twice the fetch count plus margin
   initial begin
      #(timeoutNs);
      $display("Timeout: run did not complete %0d fetches within %0d ns", numInstr, timeoutNs);
      $display("Finished with errors");
      $finish;
   end

endmodule

/* flist.f */
+incdir+verilog
verilog/armIsaPkg.sv
verilog/armCtrlPkg.sv
verilog/instrDecoder.sv
verilog/condUnit.sv
verilog/pcUnit.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/armCore.sv
tests/armCore_asserts.sv
tests/armCore_tb.sv

/* Makefile */
SIM = obj_dir/VarmCore_tb

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard verilog/*.sv) $(wildcard verilog/*.svh) $(wildcard tests/*.sv)
	verilator --binary --timing --assert -f flist.f --top-module armCore_tb -Mdir obj_dir -o VarmCore_tb

run: $(SIM)
	-./$(SIM) +verilator+error+limit+100000 > sim.log 2>&1
	@if grep -q "Finished with errors" sim.log; then echo "Simulation failed, see sim.log"; exit 1; fi
	@if ! grep -q "Finished with no errors" sim.log; then echo "Simulation ended early, see sim.log"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
